//--- rv_pkg.sv
//----------------------------------------------------------------------
// RV32I core definitions. word loads and stores only, no M extension
// memory depths must be powers of two
//----------------------------------------------------------------------
package rv_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int imem_words = 256;
   localparam int dmem_words = 256;
   localparam int imem_aw    = $clog2(imem_words);
   localparam int dmem_aw    = $clog2(dmem_words);
   localparam int mmio_bit   = 31;   // stores above this go to out_wr
   localparam logic [xlen-1:0] reset_pc = '0;

   // major opcodes, instr[6:0]
   typedef enum logic [6:0] {
      op     = 7'b0110011,
      op_imm = 7'b0010011,
      load   = 7'b0000011,
      store  = 7'b0100011,
      branch = 7'b1100011,
      jal    = 7'b1101111,
      jalr   = 7'b1100111,
      lui    = 7'b0110111,
      auipc  = 7'b0010111,
      system = 7'b1110011    // not supported, decodes as illegal
   } opcode_e;

   typedef enum logic [3:0] {
      add, sub, sll, slt, sltu,
      xor_op, srl, sra, or_op, and_op,
      pass_b
   } alu_op_e;

   //-------------------------------------------------------------------
   // stage payloads
   //-------------------------------------------------------------------
   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] instr;
   } if_id_t;

   typedef struct packed {
      logic                  valid;
      logic                  illegal;
      opcode_e               opcode;
      logic [2:0]            funct3;
      alu_op_e               alu_op;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       rs1_data;
      logic [xlen-1:0]       rs2_data;
      logic [xlen-1:0]       imm;
      logic [xlen-1:0]       pc;
      logic                  uses_imm;   // alu b from imm
   } id_ex_t;

   typedef struct packed {
      logic                  valid;
      logic                  illegal;
      opcode_e               opcode;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       result;     // alu result or store address
      logic [xlen-1:0]       store_data;
   } ex_mem_t;

   typedef struct packed {
      logic                  we;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       data;
   } wb_t;

   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] addr;
      logic [xlen-1:0] data;
   } out_wr_t;

   typedef struct packed {
      logic            taken;
      logic [xlen-1:0] target;
   } redirect_t;

endpackage

//--- alu.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// RV32I integer ops, shift amount from b[4:0]
//----------------------------------------------------------------------
module alu (
   input  logic [rv_pkg::xlen-1:0] a,
   input  logic [rv_pkg::xlen-1:0] b,
   input  rv_pkg::alu_op_e         op,
   output logic [rv_pkg::xlen-1:0] y
);

   always_comb begin
      case (op)
         rv_pkg::add:    y = a + b;
         rv_pkg::sub:    y = a - b;
         rv_pkg::sll:    y = a << b[4:0];
         rv_pkg::slt:    y = {31'b0, $signed(a) < $signed(b)};
         rv_pkg::sltu:   y = {31'b0, a < b};
         rv_pkg::xor_op: y = a ^ b;
         rv_pkg::srl:    y = a >> b[4:0];
         rv_pkg::sra:    y = $signed(a) >>> b[4:0];
         rv_pkg::or_op:  y = a | b;
         rv_pkg::and_op: y = a & b;
         rv_pkg::pass_b: y = b;      // lui
         default:        y = a + b;
      endcase
   end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// 31 registers plus hardwired x0, writeback data bypasses to reads
//----------------------------------------------------------------------
module reg_file (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
   input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
   input  rv_pkg::wb_t                   wb,
   output logic [rv_pkg::xlen-1:0]       rs1_data,
   output logic [rv_pkg::xlen-1:0]       rs2_data
);

   logic [rv_pkg::xlen-1:0] regs [1:31];

   function automatic logic [rv_pkg::xlen-1:0] rd_port(
      input logic [rv_pkg::reg_addr_w-1:0] addr
   );
      if (addr == '0)
         return '0;
      if (wb.we && wb.rd == addr)
         return wb.data;       // same-cycle write
      return regs[addr];
   endfunction

   always_comb begin
      rs1_data = rd_port(rs1_addr);
      rs2_data = rd_port(rs2_addr);
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (wb.we && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// pc and instruction rom, filled from program.hex at time zero
// pc wraps inside the rom, no fault past the end
//----------------------------------------------------------------------
module fetch_stage (
   input  logic              clk,
   input  logic              rst,
   input  rv_pkg::redirect_t redirect,
   input  logic              stop,
   output rv_pkg::if_id_t    if_id
);

   logic [rv_pkg::xlen-1:0] imem [rv_pkg::imem_words];
   logic [rv_pkg::xlen-1:0] pc;
   logic [rv_pkg::xlen-1:0] pc_next;

   initial begin
      $readmemh("program.hex", imem);
   end

   always_comb begin
      if (redirect.taken)
         pc_next = redirect.target;
      else if (stop)
         pc_next = pc;            // frozen behind an illegal instruction
      else
         pc_next = pc + 32'd4;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pc    <= rv_pkg::reset_pc;
         if_id <= '0;
      end else begin
         pc          <= pc_next;
         if_id.valid <= !(redirect.taken || stop);
         if_id.pc    <= pc;
         if_id.instr <= imem[pc[rv_pkg::imem_aw+1:2]];
      end
   end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// decode and immediates. only LW/SW are legal memory ops
// system opcode and any unknown encoding is illegal
//----------------------------------------------------------------------
module decode_stage (
   input  logic                          clk,
   input  logic                          rst,
   input  rv_pkg::if_id_t                if_id,
   input  rv_pkg::redirect_t             redirect,
   output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
   output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
   input  logic [rv_pkg::xlen-1:0]       rs1_data,
   input  logic [rv_pkg::xlen-1:0]       rs2_data,
   output logic                          stop,
   output rv_pkg::id_ex_t                id_ex
);

   logic [rv_pkg::xlen-1:0] instr;
   logic [rv_pkg::xlen-1:0] imm;
   rv_pkg::opcode_e         opcode;
   rv_pkg::alu_op_e         alu_op;
   logic [2:0]              funct3;
   logic [6:0]              funct7;
   logic                    illegal;
   logic                    uses_imm;
   logic                    stop_q;

   // funct3 to alu op, alt selects sub/sra
   function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
      case (f3)
         3'd0:    return alt ? rv_pkg::sub : rv_pkg::add;
         3'd1:    return rv_pkg::sll;
         3'd2:    return rv_pkg::slt;
         3'd3:    return rv_pkg::sltu;
         3'd4:    return rv_pkg::xor_op;
         3'd5:    return alt ? rv_pkg::sra : rv_pkg::srl;
         3'd6:    return rv_pkg::or_op;
         default: return rv_pkg::and_op;
      endcase
   endfunction

   assign instr    = if_id.instr;
   assign opcode   = rv_pkg::opcode_e'(instr[6:0]);
   assign funct3   = instr[14:12];
   assign funct7   = instr[31:25];
   assign rs1_addr = instr[19:15];
   assign rs2_addr = instr[24:20];

   always_comb begin
      imm      = {{20{instr[31]}}, instr[31:20]};   // I format
      alu_op   = rv_pkg::add;
      uses_imm = 1'b0;
      illegal  = 1'b0;
      case (opcode)
         rv_pkg::op: begin
            illegal = !(funct7 == 7'h00 ||
                        (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)));
            alu_op  = alu_sel(funct3, funct7[5]);
         end
         rv_pkg::op_imm: begin
            uses_imm = 1'b1;
            if (funct3 == 3'd1)
               illegal = funct7 != 7'h00;
            else if (funct3 == 3'd5)
               illegal = !(funct7 == 7'h00 || funct7 == 7'h20);
            alu_op = alu_sel(funct3, funct3 == 3'd5 && funct7[5]);   // addi has no sub
         end
         rv_pkg::load: begin
            uses_imm = 1'b1;
            illegal  = funct3 != 3'b010;
         end
         rv_pkg::store: begin
            imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            uses_imm = 1'b1;
            illegal  = funct3 != 3'b010;
         end
         rv_pkg::branch: begin
            imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            illegal = funct3 == 3'd2 || funct3 == 3'd3;
         end
         rv_pkg::jal:
            imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
         rv_pkg::jalr:
            illegal = funct3 != 3'd0;
         rv_pkg::lui: begin
            imm      = {instr[31:12], 12'b0};
            uses_imm = 1'b1;
            alu_op   = rv_pkg::pass_b;
         end
         rv_pkg::auipc:
            imm = {instr[31:12], 12'b0};
         rv_pkg::system:
            illegal = 1'b1;
         default:
            illegal = 1'b1;
      endcase
   end

   // sticky once a live illegal word is seen
   assign stop = stop_q || (if_id.valid && illegal && !redirect.taken);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         stop_q <= 1'b0;
         id_ex  <= '0;
      end else begin
         stop_q         <= stop;
         id_ex.valid    <= if_id.valid && !redirect.taken;
         id_ex.illegal  <= illegal;
         id_ex.opcode   <= opcode;
         id_ex.funct3   <= funct3;
         id_ex.alu_op   <= alu_op;
         id_ex.rs1      <= rs1_addr;
         id_ex.rs2      <= rs2_addr;
         id_ex.rd       <= instr[11:7];
         id_ex.rs1_data <= rs1_data;
         id_ex.rs2_data <= rs2_data;
         id_ex.imm      <= imm;
         id_ex.pc       <= if_id.pc;
         id_ex.uses_imm <= uses_imm;
      end
   end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// operand forwarding, alu, branch and jump resolution
// redirect is combinational and flushes fetch and decode the same cycle
//----------------------------------------------------------------------
module execute_stage (
   input  logic              clk,
   input  logic              rst,
   input  rv_pkg::id_ex_t    id_ex,
   input  rv_pkg::wb_t       mem_fwd,
   input  rv_pkg::wb_t       wb,
   output rv_pkg::redirect_t redirect,
   output rv_pkg::ex_mem_t   ex_mem
);

   logic [rv_pkg::xlen-1:0] a;
   logic [rv_pkg::xlen-1:0] b_reg;
   logic [rv_pkg::xlen-1:0] b;
   logic [rv_pkg::xlen-1:0] alu_y;
   logic [rv_pkg::xlen-1:0] jalr_sum;
   logic [rv_pkg::xlen-1:0] result;
   logic                    live;
   logic                    is_jal;
   logic                    is_jalr;
   logic                    cond;

   // youngest producer wins, x0 never forwarded
   function automatic logic [rv_pkg::xlen-1:0] pick(
      input logic [rv_pkg::reg_addr_w-1:0] rs,
      input logic [rv_pkg::xlen-1:0]       reg_data,
      input rv_pkg::wb_t                   near,
      input rv_pkg::wb_t                   far
   );
      if (rs != '0 && near.we && near.rd == rs)
         return near.data;
      if (rs != '0 && far.we && far.rd == rs)
         return far.data;
      return reg_data;
   endfunction

   assign a     = pick(id_ex.rs1, id_ex.rs1_data, mem_fwd, wb);
   assign b_reg = pick(id_ex.rs2, id_ex.rs2_data, mem_fwd, wb);
   assign b     = id_ex.uses_imm ? id_ex.imm : b_reg;

   alu u_alu (
      .a  (a),
      .b  (b),
      .op (id_ex.alu_op),
      .y  (alu_y)
   );

   // branch compare, separate from the alu
   always_comb begin
      case (id_ex.funct3)
         3'd0:    cond = a == b_reg;
         3'd1:    cond = a != b_reg;
         3'd4:    cond = $signed(a) < $signed(b_reg);
         3'd5:    cond = $signed(a) >= $signed(b_reg);
         3'd6:    cond = a < b_reg;
         3'd7:    cond = a >= b_reg;
         default: cond = 1'b0;
      endcase
   end

   assign live     = id_ex.valid && !id_ex.illegal;
   assign is_jal   = id_ex.opcode == rv_pkg::jal;
   assign is_jalr  = id_ex.opcode == rv_pkg::jalr;
   assign jalr_sum = a + id_ex.imm;

   assign redirect.taken  = live && (is_jal || is_jalr ||
                                     (id_ex.opcode == rv_pkg::branch && cond));
   assign redirect.target = is_jalr ? {jalr_sum[31:1], 1'b0} : id_ex.pc + id_ex.imm;

   always_comb begin
      if (is_jal || is_jalr)
         result = id_ex.pc + 32'd4;         // link
      else if (id_ex.opcode == rv_pkg::auipc)
         result = id_ex.pc + id_ex.imm;
      else
         result = alu_y;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         ex_mem <= '0;
      end else begin
         ex_mem.valid      <= id_ex.valid;
         ex_mem.illegal    <= id_ex.illegal;
         ex_mem.opcode     <= id_ex.opcode;
         ex_mem.rd         <= id_ex.rd;
         ex_mem.result     <= result;
         ex_mem.store_data <= b_reg;
      end
   end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// word-addressed data ram, async read. stores with bit 31 set go to
// out_wr only and never reach the ram
//----------------------------------------------------------------------
module mem_stage (
   input  logic            clk,
   input  logic            rst,
   input  rv_pkg::ex_mem_t ex_mem,
   output rv_pkg::wb_t     mem_fwd,
   output rv_pkg::wb_t     wb,
   output rv_pkg::out_wr_t out_wr,
   output logic            halt
);

   logic [rv_pkg::xlen-1:0]    dmem [rv_pkg::dmem_words];
   logic [rv_pkg::dmem_aw-1:0] idx;
   logic                       live;
   logic                       is_store;
   logic                       to_mmio;
   logic                       writes_rd;

   assign idx      = ex_mem.result[rv_pkg::dmem_aw+1:2];
   assign live     = ex_mem.valid && !ex_mem.illegal;
   assign is_store = live && ex_mem.opcode == rv_pkg::store;
   assign to_mmio  = ex_mem.result[rv_pkg::mmio_bit];

   always_comb begin
      case (ex_mem.opcode)
         rv_pkg::op, rv_pkg::op_imm, rv_pkg::load, rv_pkg::jal,
         rv_pkg::jalr, rv_pkg::lui, rv_pkg::auipc:
            writes_rd = 1'b1;
         default:
            writes_rd = 1'b0;
      endcase
   end

   assign mem_fwd.we   = live && writes_rd && ex_mem.rd != '0;
   assign mem_fwd.rd   = ex_mem.rd;
   assign mem_fwd.data = (ex_mem.opcode == rv_pkg::load) ? dmem[idx] : ex_mem.result;

   assign out_wr.valid = is_store && to_mmio;
   assign out_wr.addr  = ex_mem.result;
   assign out_wr.data  = ex_mem.store_data;

   always_ff @(posedge clk) begin
      if (is_store && !to_mmio)
         dmem[idx] <= ex_mem.store_data;
   end

   //-------------------------------------------------------------------
   // writeback register and halt
   //-------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wb   <= '0;
         halt <= 1'b0;
      end else begin
         wb   <= mem_fwd;
         halt <= halt || (ex_mem.valid && ex_mem.illegal);   // sticky until reset
      end
   end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// five-stage RV32I core, never stalls. both memories are internal
// program comes from program.hex, results leave through out_wr
//----------------------------------------------------------------------
module rv_core (
   input  logic            clk,
   input  logic            rst,
   output logic            halt,
   output rv_pkg::out_wr_t out_wr
);

   rv_pkg::if_id_t                if_id;
   rv_pkg::id_ex_t                id_ex;
   rv_pkg::ex_mem_t               ex_mem;
   rv_pkg::wb_t                   mem_fwd;
   rv_pkg::wb_t                   wb;
   rv_pkg::redirect_t             redirect;
   logic                          stop;
   logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
   logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
   logic [rv_pkg::xlen-1:0]       rs1_data;
   logic [rv_pkg::xlen-1:0]       rs2_data;

   fetch_stage u_fetch (
      .clk      (clk),
      .rst      (rst),
      .redirect (redirect),
      .stop     (stop),
      .if_id    (if_id)
   );

   decode_stage u_decode (
      .clk      (clk),
      .rst      (rst),
      .if_id    (if_id),
      .redirect (redirect),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .stop     (stop),
      .id_ex    (id_ex)
   );

   reg_file u_regs (
      .clk      (clk),
      .rst      (rst),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .wb       (wb),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   execute_stage u_execute (
      .clk      (clk),
      .rst      (rst),
      .id_ex    (id_ex),
      .mem_fwd  (mem_fwd),
      .wb       (wb),
      .redirect (redirect),
      .ex_mem   (ex_mem)
   );

   mem_stage u_mem (
      .clk      (clk),
      .rst      (rst),
      .ex_mem   (ex_mem),
      .mem_fwd  (mem_fwd),
      .wb       (wb),
      .out_wr   (out_wr),
      .halt     (halt)
   );

endmodule

//--- rv_core_sva.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// checks on halt and the output port, bound into every rv_core
//----------------------------------------------------------------------
module rv_core_sva (
   input logic            clk,
   input logic            rst,
   input logic            halt,
   input rv_pkg::out_wr_t out_wr
);

   // outputs quiet while reset is held
   property quiet_in_reset;
      @(posedge clk) !rst |-> (!halt && !out_wr.valid);
   endproperty

   property halt_sticky;
      @(posedge clk) disable iff (!rst) halt |=> halt;
   endproperty

   // nothing younger than the illegal word may store
   property no_write_after_halt;
      @(posedge clk) disable iff (!rst) halt |=> !out_wr.valid;
   endproperty

   a_quiet_in_reset: assert property (quiet_in_reset)
      else $error("halt or out_wr.valid is high while reset is held");

   a_halt_sticky: assert property (halt_sticky)
      else $error("halt fell without a reset");

   a_no_write_after_halt: assert property (no_write_after_halt)
      else $error("out_wr.valid pulsed after halt was raised");

endmodule

bind rv_core rv_core_sva u_sva (
   .clk    (clk),
   .rst    (rst),
   .halt   (halt),
   .out_wr (out_wr)
);

//--- tb_rv_core.sv
`timescale 1ns/1ps
//----------------------------------------------------------------------
// stimulus is reset plus program.hex, expected list matches that file
// only. outputs are sampled on the falling edge
//----------------------------------------------------------------------
module tb_rv_core;

   logic            clk;
   logic            rst;
   logic            halt;
   rv_pkg::out_wr_t out_wr;

   logic [31:0] expected [9];
   int          n_seen;
   int          value_errors;
   int          other_errors;
   int          cycles;

   rv_core u_dut (
      .clk    (clk),
      .rst    (rst),
      .halt   (halt),
      .out_wr (out_wr)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //-------------------------------------------------------------------
   // output port checks
   //-------------------------------------------------------------------
   task automatic check_output();
      logic [31:0] exp_data;
      assert (n_seen < $size(expected)) else begin
         other_errors++;
         $display("output write at %0t is beyond the end of the expected list", $time);
      end
      if (n_seen < $size(expected)) begin
         exp_data = expected[n_seen];
         assert (out_wr.data === exp_data) else begin
            value_errors++;
            $display("[ERROR] %0t out_wr.data expected %h got %h",
                     $time, exp_data, out_wr.data);
         end
      end
      assert (out_wr.addr === 32'h8000_0000) else begin
         value_errors++;
         $display("[ERROR] %0t out_wr.addr expected %h got %h",
                  $time, 32'h8000_0000, out_wr.addr);
      end
      assert (!halt) else begin
         other_errors++;
         $display("output write at %0t while the core is halted", $time);
      end
      n_seen++;
   endtask

   always @(negedge clk) begin
      if (rst && out_wr.valid)
         check_output();
   end

   //-------------------------------------------------------------------
   // main sequence
   //-------------------------------------------------------------------
   initial begin
      expected[0] = 32'hFFFF_FFFE;   // add -5 + 3
      expected[1] = 32'h0000_0040;   // (3 - -5) << 3
      expected[2] = 32'hFFFF_FFF0;   // (-5 >>> 3) ^ (-5 >> 28)
      expected[3] = 32'h0000_0060;   // slt 1, sltu 0, and, or
      expected[4] = 32'h0000_0067;   // load of 0x60 plus 7
      expected[5] = 32'h0000_00A8;   // jal link, pc 0xa4 + 4
      expected[6] = 32'h0000_00B8;   // jalr link, pc 0xb4 + 4
      expected[7] = 32'h1234_50C4;   // auipc 0x12345 at pc 0xc4
      expected[8] = 32'hABCD_E123;   // lui 0xabcde then addi 0x123

      n_seen       = 0;
      value_errors = 0;
      other_errors = 0;
      cycles       = 0;
      rst          = 1'b0;

      repeat (2) @(posedge clk);
      #1 rst = 1'b1;

      while (!halt && cycles < 2000) begin
         @(negedge clk);
         cycles++;
      end
      assert (halt) else begin
         other_errors++;
         $display("timeout: halt did not rise within 2000 cycles");
      end

      // short window in which no further output may appear
      repeat (10) @(negedge clk);

      assert (n_seen == $size(expected)) else begin
         other_errors++;
         $display("saw %0d output writes where %0d were expected",
                  n_seen, $size(expected));
      end

      $display("closing: %0d value errors, %0d other errors, %0d outputs",
               value_errors, other_errors, n_seen);
      if (value_errors == 0 && other_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- sources.f
rv_pkg.sv
alu.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
rv_core.sv
rv_core_sva.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build the rv_core testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
   -f sources.f --top-module tb_rv_core -o sim_rv_core

# a failing assertion may stop the run early, the search below decides
sim_out=$(./obj_dir/sim_rv_core 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "NO ERRORS"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

//--- program.hex
// one RV32I instruction word per line in hex, first line at address 0
// results are stored to 0x8000_0000 in the order the testbench expects
800000B7 // 00 lui  x1, 0x80000        output port base
FFB00113 // 04 addi x2, x0, -5
00300193 // 08 addi x3, x0, 3
00310233 // 0c add  x4, x2, x3         -2
0040A023 // 10 sw   x4, 0(x1)
402182B3 // 14 sub  x5, x3, x2         8
00329333 // 18 sll  x6, x5, x3         0x40
0060A023 // 1c sw   x6, 0(x1)
403153B3 // 20 sra  x7, x2, x3         -1
01C15413 // 24 srli x8, x2, 28         0xf
0083C4B3 // 28 xor  x9, x7, x8         0xfffffff0
0090A023 // 2c sw   x9, 0(x1)
00312533 // 30 slt  x10, x2, x3        1
003135B3 // 34 sltu x11, x2, x3        0
00551613 // 38 slli x12, x10, 5        0x20
00B666B3 // 3c or   x13, x12, x11      0x20
00617733 // 40 and  x14, x2, x6        0x40
00D767B3 // 44 or   x15, x14, x13      0x60
00F0A023 // 48 sw   x15, 0(x1)
00F02823 // 4c sw   x15, 16(x0)        data memory
01002803 // 50 lw   x16, 16(x0)
00780893 // 54 addi x17, x16, 7        0x67
0110A023 // 58 sw   x17, 0(x1)
00310463 // 5c beq  x2, x3, +8         not taken
00311463 // 60 bne  x2, x3, +8         taken
0000A023 // 64 sw   x0, 0(x1)          never reached
0021C463 // 68 blt  x3, x2, +8         not taken
0021D463 // 6c bge  x3, x2, +8         taken
0000A023 // 70 sw   x0, 0(x1)
00316463 // 74 bltu x2, x3, +8         not taken
00317463 // 78 bgeu x2, x3, +8         taken
0000A023 // 7c sw   x0, 0(x1)
00319463 // 80 bne  x3, x3, +8         not taken
00318463 // 84 beq  x3, x3, +8         taken
0000A023 // 88 sw   x0, 0(x1)
00315463 // 8c bge  x2, x3, +8         not taken
00314463 // 90 blt  x2, x3, +8         taken
0000A023 // 94 sw   x0, 0(x1)
0021F463 // 98 bgeu x3, x2, +8         not taken
0021E463 // 9c bltu x3, x2, +8         taken
0000A023 // a0 sw   x0, 0(x1)
0080096F // a4 jal  x18, +8            link 0xa8
0000A023 // a8 sw   x0, 0(x1)
0120A023 // ac sw   x18, 0(x1)
00000997 // b0 auipc x19, 0            0xb0
01098AE7 // b4 jalr x21, 16(x19)       to 0xc0, link 0xb8
0000A023 // b8 sw   x0, 0(x1)
0000A023 // bc sw   x0, 0(x1)
0150A023 // c0 sw   x21, 0(x1)
12345B17 // c4 auipc x22, 0x12345      0x123450c4
0160A023 // c8 sw   x22, 0(x1)
ABCDEBB7 // cc lui  x23, 0xabcde
123B8B93 // d0 addi x23, x23, 0x123    0xabcde123
0170A023 // d4 sw   x23, 0(x1)
00000073 // d8 ecall                   illegal, halts the core
0000A023 // dc sw   x0, 0(x1)          fetched but never valid
